//--- aluExecute.sv
// Operand2 register form ignores the shift field; no carry-in arithmetic
`timescale 1ns/10ps

module aluExecute (
  input  armCorePkg::aluOpT               aluOp,
  input  logic                            useImm,
  input  logic [11:0]                     imm12,      // rot[11:8], imm8[7:0]
  input  logic [armCorePkg::dataW-1:0]    opN,
  input  logic [armCorePkg::dataW-1:0]    opM,
  input  logic                            carryIn,    // Current C
  input  logic                            overflowIn, // Current V, kept by logical ops
  output logic [armCorePkg::dataW-1:0]    result,
  output armCorePkg::flagsT               flagsOut
);
  import armCorePkg::*;

  logic [4:0]         rotAmt;       // Twice the rotate field
  logic [2*dataW-1:0] immPair;
  logic [dataW-1:0]   immVal;
  logic [dataW-1:0]   opB;          // Second operand
  logic               shiftCarry;
  logic [dataW-1:0]   addX;
  logic [dataW-1:0]   addY;
  logic               addCin;
  logic [dataW:0]     sum;          // Carry in top bit
  logic               overflow;
  logic               isArith;

  // Rotate right via doubled word
  assign rotAmt  = {imm12[11:8], 1'b0};
  assign immPair = {2{{(dataW-8){1'b0}}, imm12[7:0]}} >> rotAmt;
  assign immVal  = immPair[dataW-1:0];

  assign shiftCarry = (useImm && (imm12[11:8] != 4'd0)) ? immVal[dataW-1] : carryIn;
  assign opB = useImm ? immVal : opM;

  // One adder; subtraction as invert plus one
  always_comb begin
    case (aluOp)
      opSub, opCmp: begin
        addX = opN;
        addY = ~opB;
        addCin = 1'b1;
      end
      opRsb: begin
        addX = opB; // Reverse subtract
        addY = ~opN;
        addCin = 1'b1;
      end
      default: begin
        addX = opN;
        addY = opB;
        addCin = 1'b0;
      end
    endcase
  end

  assign sum      = {1'b0, addX} + {1'b0, addY} + {{dataW{1'b0}}, addCin};
  assign overflow = (addX[dataW-1] == addY[dataW-1]) && (sum[dataW-1] != addX[dataW-1]);
  assign isArith  = aluOp inside {opSub, opRsb, opAdd, opCmp, opCmn};

  always_comb begin
    case (aluOp)
      opAnd, opTst: result = opN & opB;
      opEor, opTeq: result = opN ^ opB;
      opSub, opRsb, opAdd, opCmp, opCmn: result = sum[dataW-1:0];
      opOrr: result = opN | opB;
      opMov: result = opB;
      opBic: result = opN & ~opB;
      opMvn: result = ~opB;
      default: result = '0; // Carry-using ops
    endcase
  end

  // C is NOT borrow for subtracts
  always_comb begin
    flagsOut.n = result[dataW-1];
    flagsOut.z = (result == '0);
    flagsOut.c = isArith ? sum[dataW] : shiftCarry;
    flagsOut.v = isArith ? overflow : overflowIn;
  end

endmodule

//--- armCore.f
armCorePkg.sv
regFile.sv
instrDecoder.sv
aluExecute.sv
mulExecute.sv
resultStage.sv
armCore.sv
armCoreTb.sv

//--- armCore.sv
// Single-issue core; one instruction per instrValid, result committed at the accepting edge
`timescale 1ns/10ps

module armCore (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              instrValid,  // One word per strobe
  input  armCorePkg::instrT                 instr,
  output logic                              commitValid,
  output logic [1:0]                        commitWe,
  output logic [armCorePkg::regAddrW-1:0]   commitAddr,
  output logic [armCorePkg::regAddrW-1:0]   commitAddr2,
  output logic [armCorePkg::dataW-1:0]      commitData,
  output logic [armCorePkg::dataW-1:0]      commitData2,
  output armCorePkg::flagsT                 flags,
  output logic [armCorePkg::dataW-1:0]      pc
);
  import armCorePkg::*;

  logic [regAddrW-1:0] raN, raM, raS, raA; // Read addresses
  logic [regAddrW-1:0] wa, wa2;            // Decoded write addresses
  logic [regAddrW-1:0] rfWa, rfWa2;        // To register file
  logic [dataW-1:0]    rdN, rdM, rdS, rdA;
  logic [dataW-1:0]    wd, wd2;
  logic [1:0]          we;
  aluOpT               aluOp;
  logic                useImm;
  logic [11:0]         imm12;
  logic                isMul, isLong, mulSigned, mulAcc;
  logic                writeEn, flagsEn;
  logic [dataW-1:0]    aluResult;
  flagsT               aluFlags;
  logic [dataW-1:0]    mulLo, mulHi;
  logic                mulN, mulZ;

  instrDecoder u_instrDecoder (
    .instr(instr), .flags(flags),
    .raN(raN), .raM(raM), .raS(raS), .raA(raA),
    .aluOp(aluOp), .useImm(useImm), .imm12(imm12),
    .isMul(isMul), .isLong(isLong), .mulSigned(mulSigned), .mulAcc(mulAcc),
    .writeEn(writeEn), .flagsEn(flagsEn), .wa(wa), .wa2(wa2)
  );

  regFile u_regFile (
    .clk(clk), .we(we),
    .raN(raN), .raM(raM), .raS(raS), .raA(raA),
    .wa(rfWa), .wa2(rfWa2), .wd(wd), .wd2(wd2), .pc(pc),
    .rdN(rdN), .rdM(rdM), .rdS(rdS), .rdA(rdA)
  );

  aluExecute u_aluExecute (
    .aluOp(aluOp), .useImm(useImm), .imm12(imm12),
    .opN(rdN), .opM(rdM),
    .carryIn(flags.c), .overflowIn(flags.v), // Flags from previous instruction
    .result(aluResult), .flagsOut(aluFlags)
  );

  // RdHi comes back on the N port for long accumulate
  mulExecute u_mulExecute (
    .opM(rdM), .opS(rdS), .accLo(rdA), .accHi(rdN),
    .isLong(isLong), .mulSigned(mulSigned), .mulAcc(mulAcc),
    .lo(mulLo), .hi(mulHi), .mulN(mulN), .mulZ(mulZ)
  );

  resultStage u_resultStage (
    .clk(clk), .rst(rst), .instrValid(instrValid),
    .writeEn(writeEn), .flagsEn(flagsEn), .isMul(isMul), .isLong(isLong),
    .wa(wa), .wa2(wa2),
    .aluResult(aluResult), .aluFlags(aluFlags),
    .mulLo(mulLo), .mulHi(mulHi), .mulN(mulN), .mulZ(mulZ),
    .we(we), .waOut(rfWa), .wa2Out(rfWa2), .wd(wd), .wd2(wd2),
    .flags(flags), .pc(pc),
    .commitValid(commitValid), .commitWe(commitWe),
    .commitAddr(commitAddr), .commitAddr2(commitAddr2),
    .commitData(commitData), .commitData2(commitData2)
  );

endmodule

//--- armCorePkg.sv
// Shared core types; ARM bit layout assumed, only the DP and multiply formats are modeled
package armCorePkg;

  localparam int dataW    = 32;                     // Data word width
  localparam int regAddrW = 4;                      // Register address width
  localparam logic [regAddrW-1:0] pcReg = 4'd15;    // R15 holds the PC
  localparam logic [dataW-1:0] pcReadOffset = 32'd8; // R15 reads see PC+8
  localparam logic [dataW-1:0] pcStep = 32'd4;       // PC advance per instruction

  // ARM data-processing opcodes, full 4-bit space
  typedef enum logic [3:0] {
    opAnd = 4'h0, opEor = 4'h1, opSub = 4'h2, opRsb = 4'h3,
    opAdd = 4'h4, opAdc = 4'h5, opSbc = 4'h6, opRsc = 4'h7,
    opTst = 4'h8, opTeq = 4'h9, opCmp = 4'hA, opCmn = 4'hB,
    opOrr = 4'hC, opMov = 4'hD, opBic = 4'hE, opMvn = 4'hF
  } aluOpT;

  // Condition codes EQ..AL, 4'hF left unnamed
  typedef enum logic [3:0] {
    condEq = 4'h0, condNe = 4'h1, condCs = 4'h2, condCc = 4'h3,
    condMi = 4'h4, condPl = 4'h5, condVs = 4'h6, condVc = 4'h7,
    condHi = 4'h8, condLs = 4'h9, condGe = 4'hA, condLt = 4'hB,
    condGt = 4'hC, condLe = 4'hD, condAl = 4'hE
  } condT;

  typedef struct packed {
    condT        cond;     // [31:28]
    logic [1:0]  cls;      // [27:26] 00 for data processing
    logic        immFlag;  // [25] Operand2 is rotated immediate
    aluOpT       opcode;   // [24:21]
    logic        s;        // [20] Update flags
    logic [3:0]  rn;       // [19:16]
    logic [3:0]  rd;       // [15:12]
    logic [11:0] operand2; // [11:0] Rm in [3:0] or rot:imm8
  } dpWordT;

  typedef struct packed {
    condT       cond;      // [31:28]
    logic [3:0] fixedBits; // [27:24] Always 0000
    logic       isLong;    // [23] UMULL/SMULL
    logic       isSigned;  // [22] Signed long form
    logic       acc;       // [21] Accumulate
    logic       s;         // [20]
    logic [3:0] rdHi;      // [19:16] Rd for short forms
    logic [3:0] rdLo;      // [15:12] Rn for MLA
    logic [3:0] rs;        // [11:8]
    logic [3:0] marker;    // [7:4] Always 1001
    logic [3:0] rm;        // [3:0]
  } mulWordT;

  // One instruction word, two views
  typedef union packed {
    dpWordT  dp;
    mulWordT mul;
  } instrT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

endpackage

//--- armCoreTb.sv
// Directed and seeded random DP/multiply words; R0-R14 are loaded by MOV before any read
`timescale 1ns/10ps

module armCoreTb;
  import armCorePkg::*;

  localparam int resetCycles = 16;
  localparam int numDirected = 110; // Upper bound on directed words
  localparam int numRandom   = 300;
  // At most one bubble per word, so twice the word count is enough
  localparam int cycleLimit  = resetCycles + 2 * (numDirected + numRandom);

  typedef struct packed {
    logic [1:0]  we;
    logic [3:0]  addr;
    logic [31:0] data;
    logic [3:0]  addr2;
    logic [31:0] data2;
    logic [3:0]  flags; // N Z C V
    logic [31:0] pc;
  } commitT;

  logic        clk;
  logic        rst;
  logic        instrValid;
  logic [31:0] instrWord;
  logic        commitValid;
  logic [1:0]  commitWe;
  logic [3:0]  commitAddr;
  logic [3:0]  commitAddr2;
  logic [31:0] commitData;
  logic [31:0] commitData2;
  flagsT       flags;
  logic [31:0] pc;

  logic [31:0] modelRegs [0:14]; // Architectural R0-R14
  logic [31:0] modelPc;
  logic [3:0]  modelFlags;       // N Z C V
  commitT      pending[$];       // Expected commits in issue order
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  armCore u_armCore (
    .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instrWord),
    .commitValid(commitValid), .commitWe(commitWe),
    .commitAddr(commitAddr), .commitAddr2(commitAddr2),
    .commitData(commitData), .commitData2(commitData2),
    .flags(flags), .pc(pc)
  );

  always #50 clk = ~clk; // 100 ns period

  // Instruction word builders, ARM bit layout
  function automatic logic [31:0] encodeDpImm(input logic [3:0] cond, input logic [3:0] op,
      input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rot,
      input logic [7:0] imm8);
    return {cond, 2'b00, 1'b1, op, s, rn, rd, rot, imm8};
  endfunction

  function automatic logic [31:0] encodeDpReg(input logic [3:0] cond, input logic [3:0] op,
      input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rm);
    return {cond, 2'b00, 1'b0, op, s, rn, rd, 8'h00, rm}; // Shift field zero
  endfunction

  function automatic logic [31:0] encodeMul(input logic [3:0] cond, input logic isLong,
      input logic sgn, input logic acc, input logic s, input logic [3:0] hi,
      input logic [3:0] lo, input logic [3:0] rs, input logic [3:0] rm);
    return {cond, 4'b0000, isLong, sgn, acc, s, hi, lo, rs, 4'b1001, rm};
  endfunction

  // ARM condition table
  function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    n = f[3];
    z = f[2];
    c = f[1];
    v = f[0];
    case (cond)
      condEq: return z;
      condNe: return !z;
      condCs: return c;
      condCc: return !c;
      condMi: return n;
      condPl: return !n;
      condVs: return v;
      condVc: return !v;
      condHi: return c && !z;
      condLs: return !c || z;
      condGe: return n == v;
      condLt: return n != v;
      condGt: return !z && (n == v);
      condLe: return z || (n != v);
      condAl: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] readModelReg(input logic [3:0] r);
    return (r == 4'd15) ? modelPc + 32'd8 : modelRegs[r]; // PC+8 view
  endfunction

  function automatic void storeModelReg(input logic [3:0] r, input logic [31:0] value);
    if (r != 4'd15) modelRegs[r] = value; // R15 writes dropped
  endfunction

  // Reference model, one word per call, updates regs, flags and PC
  function automatic commitT predictCommit(input logic [31:0] iw);
    commitT      e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] immWord;
    logic [63:0] prod;
    logic [32:0] wide;
    logic [3:0]  op;
    logic        shC;
    logic        carry;
    logic        ovf;
    int          r;
    e = '0;
    if (iw[27:24] == 4'b0000 && iw[7:4] == 4'b1001) begin
      a = readModelReg(iw[3:0]);  // Rm
      b = readModelReg(iw[11:8]); // Rs
      if (iw[23] && iw[22]) prod = 64'(longint'($signed(a)) * longint'($signed(b)));
      else prod = {32'd0, a} * {32'd0, b};
      if (iw[21]) begin
        if (iw[23]) prod = prod + {readModelReg(iw[19:16]), readModelReg(iw[15:12])};
        else prod = prod + {32'd0, readModelReg(iw[15:12])};
      end
      if (condHolds(iw[31:28], modelFlags)) begin
        if (iw[23]) begin
          e.we = 2'b11;
          e.addr = iw[15:12];  // RdLo
          e.data = prod[31:0];
          e.addr2 = iw[19:16]; // RdHi
          e.data2 = prod[63:32];
          storeModelReg(iw[15:12], prod[31:0]);
          storeModelReg(iw[19:16], prod[63:32]);
          if (iw[20]) modelFlags[3:2] = {prod[63], prod == 64'd0};
        end else begin
          e.we = 2'b01;
          e.addr = iw[19:16];
          e.data = prod[31:0];
          storeModelReg(iw[19:16], prod[31:0]);
          if (iw[20]) modelFlags[3:2] = {prod[31], prod[31:0] == 32'd0}; // C V kept
        end
      end
    end else begin
      op = iw[24:21];
      a  = readModelReg(iw[19:16]);
      if (iw[25]) begin
        r = 2 * int'(iw[11:8]);
        immWord = {24'd0, iw[7:0]};
        b = (r == 0) ? immWord : ((immWord >> r) | (immWord << (32 - r)));
        shC = (r == 0) ? modelFlags[1] : b[31];
      end else begin
        b = readModelReg(iw[3:0]);
        shC = modelFlags[1];
      end
      carry = shC;
      ovf = modelFlags[0]; // Logical ops keep V
      case (op)
        opAnd, opTst: res = a & b;
        opEor: res = a ^ b;
        opOrr: res = a | b;
        opMov: res = b;
        opBic: res = a & ~b;
        opMvn: res = ~b;
        opSub, opCmp: begin
          res = a - b;
          carry = (a >= b); // Set when no borrow
          ovf = (a[31] != b[31]) && (res[31] != a[31]);
        end
        opRsb: begin
          res = b - a;
          carry = (b >= a);
          ovf = (a[31] != b[31]) && (res[31] != b[31]);
        end
        opAdd: begin
          wide = {1'b0, a} + {1'b0, b};
          res = wide[31:0];
          carry = wide[32];
          ovf = (a[31] == b[31]) && (res[31] != a[31]);
        end
        default: res = 32'd0;
      endcase
      if (condHolds(iw[31:28], modelFlags)) begin
        if (op != opCmp && op != opTst) begin
          e.we = 2'b01;
          e.addr = iw[15:12];
          e.data = res;
          storeModelReg(iw[15:12], res);
        end
        if (iw[20]) modelFlags = {res[31], res == 32'd0, carry, ovf};
      end
    end
    modelPc = modelPc + 32'd4; // Skipped words advance too
    e.flags = modelFlags;
    e.pc = modelPc;
    return e;
  endfunction

  function automatic logic [3:0] pickDpOp(input int k);
    case (k)
      0: return opAnd;
      1: return opEor;
      2: return opSub;
      3: return opRsb;
      4: return opAdd;
      5: return opOrr;
      6: return opMov;
      7: return opBic;
      8: return opMvn;
      9: return opCmp;
      default: return opTst;
    endcase
  endfunction

  // Random word; multiplies avoid R15 and equal RdLo/RdHi
  function automatic logic [31:0] randomInstr();
    logic [3:0] cond;
    logic [3:0] op;
    logic [3:0] lo;
    logic [3:0] hi;
    logic       s;
    cond = ($urandom % 3 == 0) ? 4'($urandom % 15) : 4'(condAl);
    s    = 1'($urandom % 2);
    if ($urandom % 6 == 0) begin
      lo = 4'($urandom % 15);
      hi = 4'((32'(lo) + 1 + $urandom % 14) % 15);
      return encodeMul(cond, 1'($urandom % 2), 1'($urandom % 2), 1'($urandom % 2), s,
                       hi, lo, 4'($urandom % 15), 4'($urandom % 15));
    end
    op = pickDpOp(int'($urandom % 11));
    if (op == opCmp || op == opTst) s = 1'b1;
    if ($urandom % 2 == 0) begin
      return encodeDpImm(cond, op, s, 4'($urandom), 4'($urandom), 4'($urandom), 8'($urandom));
    end
    return encodeDpReg(cond, op, s, 4'($urandom), 4'($urandom), 4'($urandom));
  endfunction

  task automatic issueInstr(input logic [31:0] iw);
    @(posedge clk);
    instrValid <= 1'b1;
    instrWord  <= iw;
    pending.push_back(predictCommit(iw));
  endtask

  task automatic idleCycle();
    @(posedge clk);
    instrValid <= 1'b0;
  endtask

  // One CMP/ADDS setup, then every condition code on a MOV into R14
  task automatic sweepConditions(input logic [31:0] setup);
    issueInstr(setup);
    for (int c = 0; c < 15; c++) begin
      issueInstr(encodeDpImm(4'(c), opMov, 1'b0, 4'd0, 4'd14, 4'd0, 8'(c + 1)));
    end
  endtask

  task automatic runDirected();
    for (int r = 0; r < 15; r++) begin
      issueInstr(encodeDpImm(condAl, opMov, 1'b0, 4'd0, 4'(r), 4'(r), 8'(8'h0F + 8'(r) * 8'h13)));
    end
    issueInstr(encodeDpReg(condAl, opAdd, 1'b0, 4'd2, 4'd1, 4'd3));         // R1 = R2 + R3
    issueInstr(encodeDpImm(condAl, opSub, 1'b0, 4'd5, 4'd4, 4'd4, 8'hA5));  // Rotated by 8
    issueInstr(encodeDpReg(condAl, opAnd, 1'b0, 4'd7, 4'd6, 4'd8));
    issueInstr(encodeDpImm(condAl, opEor, 1'b0, 4'd10, 4'd9, 4'd0, 8'hFF));
    issueInstr(encodeDpReg(condAl, opOrr, 1'b0, 4'd12, 4'd11, 4'd13));
    issueInstr(encodeDpImm(condAl, opBic, 1'b0, 4'd1, 4'd0, 4'd0, 8'h0F));
    issueInstr(encodeDpReg(condAl, opMvn, 1'b0, 4'd0, 4'd2, 4'd3));
    issueInstr(encodeDpImm(condAl, opRsb, 1'b0, 4'd6, 4'd5, 4'd0, 8'h40));
    issueInstr(encodeDpImm(condAl, opAdd, 1'b0, 4'd15, 4'd7, 4'd0, 8'h00)); // PC+8 as Rn
    issueInstr(encodeDpReg(condAl, opMov, 1'b0, 4'd0, 4'd8, 4'd15));        // PC+8 as Rm
    issueInstr(encodeDpReg(condAl, opAdd, 1'b0, 4'd1, 4'd15, 4'd2));        // Dropped write
    // Flag setting forms
    issueInstr(encodeDpImm(condAl, opMov, 1'b1, 4'd0, 4'd8, 4'd1, 8'h02));  // 0x80000000, C=1
    issueInstr(encodeDpReg(condAl, opAdd, 1'b1, 4'd8, 4'd9, 4'd8));         // Z C V
    issueInstr(encodeDpReg(condAl, opSub, 1'b1, 4'd1, 4'd10, 4'd2));
    issueInstr(encodeDpImm(condAl, opAdd, 1'b1, 4'd1, 4'd11, 4'd0, 8'h01));
    issueInstr(encodeDpReg(condAl, opCmp, 1'b1, 4'd3, 4'd0, 4'd3));
    issueInstr(encodeDpReg(condAl, opCmp, 1'b1, 4'd0, 4'd0, 4'd1));
    issueInstr(encodeDpImm(condAl, opTst, 1'b1, 4'd4, 4'd0, 4'd0, 8'h00));
    sweepConditions(encodeDpReg(condAl, opCmp, 1'b1, 4'd3, 4'd0, 4'd3));   // Z C
    sweepConditions(encodeDpImm(condAl, opCmp, 1'b1, 4'd8, 4'd0, 4'd0, 8'h01)); // C V
    sweepConditions(encodeDpImm(condAl, opCmp, 1'b1, 4'd9, 4'd0, 4'd0, 8'h01)); // N
    // Multiplies
    issueInstr(encodeMul(condAl, 1'b0, 1'b0, 1'b0, 1'b0, 4'd10, 4'd0, 4'd2, 4'd1)); // MUL
    issueInstr(encodeMul(condAl, 1'b0, 1'b0, 1'b1, 1'b0, 4'd11, 4'd5, 4'd4, 4'd3)); // MLA
    issueInstr(encodeMul(condAl, 1'b0, 1'b0, 1'b0, 1'b1, 4'd12, 4'd0, 4'd8, 4'd8)); // MULS
    issueInstr(encodeMul(condAl, 1'b1, 1'b0, 1'b0, 1'b0, 4'd1, 4'd0, 4'd14, 4'd13)); // UMULL
    issueInstr(encodeMul(condAl, 1'b1, 1'b1, 1'b0, 1'b0, 4'd3, 4'd2, 4'd13, 4'd8)); // SMULL
    issueInstr(encodeMul(condAl, 1'b1, 1'b0, 1'b1, 1'b0, 4'd1, 4'd0, 4'd5, 4'd4));  // UMLAL
    issueInstr(encodeMul(condAl, 1'b1, 1'b1, 1'b1, 1'b1, 4'd3, 4'd2, 4'd7, 4'd6));  // SMLALS
    issueInstr(encodeMul(condNe, 1'b0, 1'b0, 1'b0, 1'b0, 4'd6, 4'd0, 4'd1, 4'd2));  // MULNE
  endtask

  task automatic runRandom();
    for (int i = 0; i < numRandom; i++) begin
      if ($urandom % 5 == 0) idleCycle(); // Occasional bubble
      issueInstr(randomInstr());
    end
  endtask

  // Commit checker, outputs are settled at the falling edge
  always @(negedge clk) begin : checkCommit
    commitT want;
    if (!rst && commitValid) begin
      if (pending.size() == 0) begin
        errors++;
        $display("** Error @ %t: commit seen with no instruction outstanding", $time);
      end else begin
        want = pending.pop_front();
        checks++;
        if (commitWe !== want.we) begin
          errors++;
          $display("** Error @ %t: commitWe %b, expected %b", $time, commitWe, want.we);
        end
        if (want.we[0] && (commitAddr !== want.addr || commitData !== want.data)) begin
          errors++;
          $display("** Error @ %t: write R%0d=%h, expected R%0d=%h", $time,
                   commitAddr, commitData, want.addr, want.data);
        end
        if (want.we == 2'b11 && (commitAddr2 !== want.addr2 || commitData2 !== want.data2)) begin
          errors++;
          $display("** Error @ %t: high write R%0d=%h, expected R%0d=%h", $time,
                   commitAddr2, commitData2, want.addr2, want.data2);
        end
        if (flags !== want.flags) begin
          errors++;
          $display("** Error @ %t: NZCV %b, expected %b", $time, flags, want.flags);
        end
        if (pc !== want.pc) begin
          errors++;
          $display("** Error @ %t: pc %h, expected %h", $time, pc, want.pc);
        end
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: run still busy after %0d cycles, %0d commits outstanding",
               cycles, pending.size());
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'h983d)); // Fixed seed for the whole run
    clk = 1'b0;
    rst <= 1'b1;
    instrValid <= 1'b0;
    instrWord <= 32'd0;
    modelPc = 32'd0;
    modelFlags = 4'd0;
    repeat (resetCycles - 1) @(posedge clk);
    @(negedge clk);
    if (commitValid !== 1'b0 || commitWe !== 2'b00 || flags !== 4'd0 || pc !== 32'd0) begin
      errors++;
      $display("** Error @ %t: reset state commitValid=%b commitWe=%b flags=%b pc=%h", $time,
               commitValid, commitWe, flags, pc);
    end
    @(posedge clk);
    rst <= 1'b0;
    runDirected();
    runRandom();
    idleCycle();
    while (pending.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk); // Catch stray commits
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- instrDecoder.sv
// Decodes DP and multiply words only; other classes and ADC/SBC/RSC commit nothing
`timescale 1ns/10ps

module instrDecoder (
  input  armCorePkg::instrT                 instr,
  input  armCorePkg::flagsT                 flags,
  output logic [armCorePkg::regAddrW-1:0]   raN,
  output logic [armCorePkg::regAddrW-1:0]   raM,
  output logic [armCorePkg::regAddrW-1:0]   raS,
  output logic [armCorePkg::regAddrW-1:0]   raA,
  output armCorePkg::aluOpT                 aluOp,
  output logic                              useImm,
  output logic [11:0]                       imm12,
  output logic                              isMul,
  output logic                              isLong,
  output logic                              mulSigned,
  output logic                              mulAcc,
  output logic                              writeEn,   // Condition already applied
  output logic                              flagsEn,
  output logic [armCorePkg::regAddrW-1:0]   wa,
  output logic [armCorePkg::regAddrW-1:0]   wa2
);
  import armCorePkg::*;

  logic isDp;       // Valid data-processing word
  logic isTest;     // TST/TEQ/CMP/CMN, flags only
  logic isCarryOp;  // ADC/SBC/RSC, not supported
  logic pass;       // Condition met

  // ARM condition check against NZCV
  function automatic logic condPass(input condT cond, input flagsT f);
    case (cond)
      condEq:  return f.z;
      condNe:  return !f.z;
      condCs:  return f.c;
      condCc:  return !f.c;
      condMi:  return f.n;
      condPl:  return !f.n;
      condVs:  return f.v;
      condVc:  return !f.v;
      condHi:  return f.c && !f.z;
      condLs:  return !f.c || f.z;
      condGe:  return f.n == f.v;
      condLt:  return f.n != f.v;
      condGt:  return !f.z && (f.n == f.v);
      condLe:  return f.z || (f.n != f.v);
      condAl:  return 1'b1;
      default: return 1'b0; // 4'hF never executes
    endcase
  endfunction

  // Multiply marker takes priority over the DP view
  assign isMul = (instr.mul.fixedBits == 4'b0000) && (instr.mul.marker == 4'b1001);
  assign isDp  = (instr.dp.cls == 2'b00) && !isMul;
  assign pass  = condPass(instr.dp.cond, flags);

  // Register fields sit at the same bits in both views
  assign raN = instr.dp.rn;   // Also RdHi, accumulator high
  assign raM = instr.mul.rm;  // Also DP Rm in operand2[3:0]
  assign raS = instr.mul.rs;
  assign raA = instr.mul.rdLo; // MLA Rn or accumulator low

  // DP control
  assign aluOp  = instr.dp.opcode;
  assign useImm = instr.dp.immFlag;
  assign imm12  = instr.dp.operand2;

  assign isTest    = aluOp inside {opTst, opTeq, opCmp, opCmn};
  assign isCarryOp = aluOp inside {opAdc, opSbc, opRsc};

  // Multiply control
  assign isLong    = isMul && instr.mul.isLong;
  assign mulSigned = instr.mul.isSigned;
  assign mulAcc    = instr.mul.acc;

  // Compare ops write flags only
  assign writeEn = pass && (isMul || (isDp && !isTest && !isCarryOp));
  assign flagsEn = pass && (isMul ? instr.mul.s : (isDp && !isCarryOp && instr.dp.s));

  // Short multiply writes Rd at [19:16], long writes RdLo then RdHi
  always_comb begin
    if (isMul) begin
      wa = isLong ? instr.mul.rdLo : instr.mul.rdHi;
    end else begin
      wa = instr.dp.rd;
    end
  end

  assign wa2 = instr.mul.rdHi; // Used only with we 11

endmodule

//--- mulExecute.sv
// Low 32 bits are sign independent, so mulSigned matters only for the long forms
`timescale 1ns/10ps

module mulExecute (
  input  logic [armCorePkg::dataW-1:0] opM,
  input  logic [armCorePkg::dataW-1:0] opS,
  input  logic [armCorePkg::dataW-1:0] accLo, // Rn for MLA, RdLo for long
  input  logic [armCorePkg::dataW-1:0] accHi, // RdHi for long accumulate
  input  logic                         isLong,
  input  logic                         mulSigned,
  input  logic                         mulAcc,
  output logic [armCorePkg::dataW-1:0] lo,
  output logic [armCorePkg::dataW-1:0] hi,
  output logic                         mulN,
  output logic                         mulZ
);
  import armCorePkg::*;

  logic [2*dataW-1:0] extM;
  logic [2*dataW-1:0] extS;
  logic [2*dataW-1:0] product;
  logic [2*dataW-1:0] accum;
  logic [2*dataW-1:0] total;
  logic               signExt;

  assign signExt = isLong && mulSigned;

  // Extend to 64 bits, then one unsigned multiply keeps the low half
  assign extM = signExt ? {{dataW{opM[dataW-1]}}, opM} : {{dataW{1'b0}}, opM};
  assign extS = signExt ? {{dataW{opS[dataW-1]}}, opS} : {{dataW{1'b0}}, opS};
  assign product = extM * extS;

  assign accum = isLong ? {accHi, accLo} : {{dataW{1'b0}}, accLo};
  assign total = product + (mulAcc ? accum : '0);

  assign lo = total[dataW-1:0];
  assign hi = total[2*dataW-1:dataW];

  // Flags from the width actually written
  assign mulN = isLong ? total[2*dataW-1] : total[dataW-1];
  assign mulZ = isLong ? (total == '0) : (lo == '0);

endmodule

//--- regFile.sv
// R0-R14 are unreset storage; R15 reads give pc+8 and R15 writes are dropped
`timescale 1ns/10ps

module regFile (
  input  logic                              clk,
  input  logic [1:0]                        we,   // 00 none, 01 wa only, 11 wa and wa2
  input  logic [armCorePkg::regAddrW-1:0]   raN,
  input  logic [armCorePkg::regAddrW-1:0]   raM,
  input  logic [armCorePkg::regAddrW-1:0]   raS,  // Multiplier operand
  input  logic [armCorePkg::regAddrW-1:0]   raA,  // Accumulator low
  input  logic [armCorePkg::regAddrW-1:0]   wa,
  input  logic [armCorePkg::regAddrW-1:0]   wa2,  // High half of long multiply
  input  logic [armCorePkg::dataW-1:0]      wd,
  input  logic [armCorePkg::dataW-1:0]      wd2,
  input  logic [armCorePkg::dataW-1:0]      pc,   // Address of current instruction
  output logic [armCorePkg::dataW-1:0]      rdN,
  output logic [armCorePkg::dataW-1:0]      rdM,
  output logic [armCorePkg::dataW-1:0]      rdS,
  output logic [armCorePkg::dataW-1:0]      rdA
);
  import armCorePkg::*;

  logic [dataW-1:0] regs [0:pcReg-1]; // R0..R14
  logic [dataW-1:0] pcRead;           // Pipeline view of R15

  assign pcRead = pc + pcReadOffset;

  // Rising edge write, read at the start of the next cycle
  always_ff @(posedge clk) begin
    case (we)
      2'b01: begin
        if (wa != pcReg) regs[wa] <= wd;
      end
      2'b11: begin
        if (wa != pcReg) regs[wa] <= wd;
        if (wa2 != pcReg) regs[wa2] <= wd2; // Wins when wa equals wa2
      end
      default: begin
        // No write
      end
    endcase
  end

  assign rdN = (raN == pcReg) ? pcRead : regs[raN];
  assign rdM = (raM == pcReg) ? pcRead : regs[raM];
  assign rdS = (raS == pcReg) ? pcRead : regs[raS];
  assign rdA = (raA == pcReg) ? pcRead : regs[raA];

endmodule

//--- resultStage.sv
// Assumes one instruction per instrValid edge; no back-pressure, commit outputs last one cycle
`timescale 1ns/10ps

module resultStage (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              instrValid,
  input  logic                              writeEn,
  input  logic                              flagsEn,
  input  logic                              isMul,
  input  logic                              isLong,
  input  logic [armCorePkg::regAddrW-1:0]   wa,
  input  logic [armCorePkg::regAddrW-1:0]   wa2,
  input  logic [armCorePkg::dataW-1:0]      aluResult,
  input  armCorePkg::flagsT                 aluFlags,
  input  logic [armCorePkg::dataW-1:0]      mulLo,
  input  logic [armCorePkg::dataW-1:0]      mulHi,
  input  logic                              mulN,
  input  logic                              mulZ,
  output logic [1:0]                        we,
  output logic [armCorePkg::regAddrW-1:0]   waOut,
  output logic [armCorePkg::regAddrW-1:0]   wa2Out,
  output logic [armCorePkg::dataW-1:0]      wd,
  output logic [armCorePkg::dataW-1:0]      wd2,
  output armCorePkg::flagsT                 flags,
  output logic [armCorePkg::dataW-1:0]      pc,
  output logic                              commitValid,
  output logic [1:0]                        commitWe,
  output logic [armCorePkg::regAddrW-1:0]   commitAddr,
  output logic [armCorePkg::regAddrW-1:0]   commitAddr2,
  output logic [armCorePkg::dataW-1:0]      commitData,
  output logic [armCorePkg::dataW-1:0]      commitData2
);
  import armCorePkg::*;

  flagsT nextFlags;

  // Register file write, same encoding as the commit port
  always_comb begin
    we = 2'b00;
    if (instrValid && writeEn) begin
      we = isLong ? 2'b11 : 2'b01;
    end
  end

  assign waOut  = wa;
  assign wa2Out = wa2;
  assign wd     = isMul ? mulLo : aluResult;
  assign wd2    = mulHi; // Long forms only

  // Multiply keeps C and V
  assign nextFlags = isMul ? flagsT'{n: mulN, z: mulZ, c: flags.c, v: flags.v} : aluFlags;

  always_ff @(posedge clk) begin
    if (rst) begin
      flags       <= '0;
      pc          <= '0;
      commitValid <= 1'b0;
      commitWe    <= 2'b00;
    end else begin
      commitValid <= instrValid;  // Skipped instructions still pulse
      commitWe    <= we;
      if (instrValid) begin
        pc <= pc + pcStep;
        if (flagsEn) flags <= nextFlags;
      end
    end
  end

  // Commit payload
  always_ff @(posedge clk) begin
    commitAddr  <= wa;
    commitAddr2 <= wa2;
    commitData  <= wd;
    commitData2 <= wd2;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the armCore testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f armCore.f --top-module armCoreTb \
  -Mdir obj_dir -o armCoreSim

./obj_dir/armCoreSim 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation passed"
